/* common/msiptw_pkg.sv */
package msiptw_pkg;

    // Address and data widths
    localparam int GPLEN       = 41;
    localparam int PPNW        = 44;
    localparam int PLEN        = 56;
    localparam int PG_OFF_W    = 12;
    localparam int WB_DW       = 64;
    localparam int CAUSE_LEN   = 12;
    localparam int MRIF_ADDR_W = 47;
    localparam int NID_W       = 11;

    // One MSI PTE is 16 bytes; word 1 sits at +8
    localparam int              PTE_STRIDE_SHIFT = 4;
    localparam logic [PLEN-1:0] PTE_HI_OFF       = 56'd8;

    // Word 0, common fields
    localparam int W0_V        = 0;
    localparam int W0_M_LSB    = 1;
    localparam int W0_M_MSB    = 2;
    localparam int W0_C        = 63;
    localparam int W0_RSVL_LSB = 3;
    localparam int W0_RSVH_LSB = 54;
    localparam int W0_RSVH_MSB = 62;

    // Word 0, flat mode
    localparam int FLAT_RSV_MSB = 9;
    localparam int FLAT_PPN_LSB = 10;
    localparam int FLAT_PPN_MSB = 53;

    // Word 0, MRIF mode
    localparam int MRIF_RSV_MSB  = 6;
    localparam int MRIF_ADDR_LSB = 7;
    localparam int MRIF_ADDR_MSB = 53;

    // Word 1, notice fields
    localparam int NID_LO_MSB  = 9;
    localparam int NPPN_LSB    = 10;
    localparam int NPPN_MSB    = 53;
    localparam int W1_RSVA_LSB = 54;
    localparam int W1_RSVA_MSB = 59;
    localparam int NID_HI      = 60;
    localparam int W1_RSVB_LSB = 61;
    localparam int W1_RSVB_MSB = 63;

    // PTE mode, other encodings reserved
    typedef enum logic [1:0] {
        MODE_MRIF = 2'd1,
        MODE_FLAT = 2'd3
    } msi_mode_e;

    // Fault causes reported on error
    typedef enum logic [CAUSE_LEN-1:0] {
        CAUSE_INSTR_FAULT  = 12'd1,
        CAUSE_PTE_INVALID  = 12'd262,
        CAUSE_PTE_MISCONF  = 12'd263,
        CAUSE_DATA_CORRUPT = 12'd270
    } msi_cause_e;

endpackage

/* msiptw/msi_addr_calc.sv */
`timescale 1ns/100ps

module msi_addr_calc #(
    parameter int MaskLen = 16
) (
    input  logic [msiptw_pkg::GPLEN-1:0] iova_i,
    input  logic [msiptw_pkg::PPNW-1:0]  msiptp_ppn_i,
    input  logic [MaskLen-1:0]           msi_mask_i,
    output logic [msiptw_pkg::PLEN-1:0]  pte_addr_o
);

    localparam int GppnW = msiptw_pkg::GPLEN - msiptw_pkg::PG_OFF_W;

    logic [GppnW-1:0]              gppn;
    logic [MaskLen-1:0]            file_num;
    logic [msiptw_pkg::PLEN-1:0]   file_off;

    // Guest page number of the request
    assign gppn = iova_i[msiptw_pkg::GPLEN-1:msiptw_pkg::PG_OFF_W];

    // Gather masked GPPN bits into a packed file number, LSB first
    always_comb begin
        int unsigned n;
        n        = 0;
        file_num = '0;
        for (int i = 0; i < MaskLen; i++) begin
            if (msi_mask_i[i]) begin
                file_num[n] = gppn[i];
                n++;
            end
        end
    end

    // Each file owns one 16-byte PTE slot in the table
    assign file_off   = {{(msiptw_pkg::PLEN - MaskLen){1'b0}}, file_num}
                        << msiptw_pkg::PTE_STRIDE_SHIFT;
    assign pte_addr_o = {msiptp_ppn_i, {msiptw_pkg::PG_OFF_W{1'b0}}} | file_off;

endmodule

/* msiptw/pte_reader.sv */
`timescale 1ns/100ps

module pte_reader (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         rd_lo_i,
    input  logic                         rd_hi_i,
    input  logic [msiptw_pkg::PLEN-1:0]  base_i,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output logic [msiptw_pkg::PLEN-1:0]  wb_adr_o,
    input  logic [msiptw_pkg::WB_DW-1:0] wb_dat_i,
    input  logic                         wb_ack_i,
    input  logic                         wb_err_i,
    output logic                         rsp_valid_o,
    output logic                         rsp_err_o,
    output logic [msiptw_pkg::WB_DW-1:0] rsp_data_o
);

    logic [msiptw_pkg::PLEN-1:0] base_q;
    logic                        cyc_q;
    logic                        hi_q;
    logic                        cyc_end;

    // Either ack or err closes the classic cycle
    assign cyc_end = cyc_q && (wb_ack_i || wb_err_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q <= 1'b0;
            hi_q  <= 1'b0;
        end else if (rd_lo_i || rd_hi_i) begin
            cyc_q <= 1'b1;
            hi_q  <= rd_hi_i;
        end else if (cyc_end) begin
            cyc_q <= 1'b0;
        end
    end

    // PTE base kept for the word 1 read
    always_ff @(posedge clk_i) begin
        if (rd_lo_i) begin
            base_q <= base_i;
        end
    end

    // Read-only master, stb tied to cyc
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = hi_q ? base_q + msiptw_pkg::PTE_HI_OFF : base_q;

    // Response only in the ack/err cycle
    assign rsp_valid_o = cyc_end;
    assign rsp_err_o   = cyc_q && wb_err_i;
    assign rsp_data_o  = wb_dat_i;

endmodule

/* msiptw/flat_walker.sv */
`timescale 1ns/100ps

module flat_walker #(
    parameter bit MrifEn  = 1'b1,
    parameter int MaskLen = 16
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         start_i,
    input  logic [msiptw_pkg::GPLEN-1:0] iova_i,
    input  logic                         is_rx_i,
    input  logic [msiptw_pkg::PPNW-1:0]  msiptp_ppn_i,
    input  logic [MaskLen-1:0]           msi_mask_i,
    input  logic                         rsp_valid_i,
    input  logic                         rsp_err_i,
    input  logic [msiptw_pkg::WB_DW-1:0] rsp_data_i,
    input  logic                         mrif_done_i,
    output logic                         busy_o,
    output logic                         rd_lo_o,
    output logic [msiptw_pkg::PLEN-1:0]  base_o,
    output logic                         mrif_start_o,
    output logic                         iotlb_update_o,
    output logic [msiptw_pkg::PPNW-1:0]  iotlb_ppn_o,
    output logic                         flat_error_o,
    output msiptw_pkg::msi_cause_e       flat_cause_o
);

    typedef enum logic [1:0] {IDLE, FETCH_LO, WAIT_MRIF, FAULT} state_e;

    state_e                      state_q, state_n;
    msiptw_pkg::msi_cause_e      cause_q, cause_n;
    msiptw_pkg::msi_mode_e       mode;
    logic                        sent_q, sent_n;
    logic                        upd_q, upd_n;
    logic                        flat_rsv;
    logic [msiptw_pkg::PPNW-1:0] ppn_q;

    // PTE address straight from the request, inputs stay stable while busy
    msi_addr_calc #(.MaskLen(MaskLen)) i_addr_calc (
        .iova_i       (iova_i),
        .msiptp_ppn_i (msiptp_ppn_i),
        .msi_mask_i   (msi_mask_i),
        .pte_addr_o   (base_o)
    );

    // Word 0 decode
    assign mode     = msiptw_pkg::msi_mode_e'(rsp_data_i[msiptw_pkg::W0_M_MSB:msiptw_pkg::W0_M_LSB]);
    assign flat_rsv = (|rsp_data_i[msiptw_pkg::FLAT_RSV_MSB:msiptw_pkg::W0_RSVL_LSB])
                   || (|rsp_data_i[msiptw_pkg::W0_RSVH_MSB:msiptw_pkg::W0_RSVH_LSB]);

    always_comb begin
        state_n      = state_q;
        cause_n      = cause_q;
        sent_n       = sent_q;
        upd_n        = 1'b0;
        rd_lo_o      = 1'b0;
        mrif_start_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_i && !busy_o) begin
                    sent_n  = 1'b0;
                    state_n = FETCH_LO;
                end
            end
            FETCH_LO: begin
                // First cycle decides between exec fault and the bus read
                if (!sent_q) begin
                    if (is_rx_i) begin
                        cause_n = msiptw_pkg::CAUSE_INSTR_FAULT;
                        state_n = FAULT;
                    end else begin
                        rd_lo_o = 1'b1;
                        sent_n  = 1'b1;
                    end
                end else if (rsp_valid_i) begin
                    state_n = FAULT;
                    if (rsp_err_i) begin
                        cause_n = msiptw_pkg::CAUSE_DATA_CORRUPT;
                    end else if (!rsp_data_i[msiptw_pkg::W0_V] || rsp_data_i[msiptw_pkg::W0_C]) begin
                        // Custom format counts as invalid
                        cause_n = msiptw_pkg::CAUSE_PTE_INVALID;
                    end else if (mode == msiptw_pkg::MODE_MRIF && MrifEn) begin
                        mrif_start_o = 1'b1;
                        state_n      = WAIT_MRIF;
                    end else if (mode == msiptw_pkg::MODE_FLAT && !flat_rsv) begin
                        upd_n   = 1'b1;
                        state_n = IDLE;
                    end else begin
                        // Reserved mode, MRIF off, or flat reserved bits
                        cause_n = msiptw_pkg::CAUSE_PTE_MISCONF;
                    end
                end
            end
            WAIT_MRIF: begin
                if (mrif_done_i) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cause_q <= msiptw_pkg::CAUSE_INSTR_FAULT;
            sent_q  <= 1'b0;
            upd_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            cause_q <= cause_n;
            sent_q  <= sent_n;
            upd_q   <= upd_n;
        end
    end

    // Flat PPN held for the update cycle
    always_ff @(posedge clk_i) begin
        if (upd_n) begin
            ppn_q <= rsp_data_i[msiptw_pkg::FLAT_PPN_MSB:msiptw_pkg::FLAT_PPN_LSB];
        end
    end

    // Update cycle still counts as busy
    assign busy_o         = (state_q != IDLE) || upd_q;
    assign iotlb_update_o = upd_q;
    assign iotlb_ppn_o    = ppn_q;
    assign flat_error_o   = (state_q == FAULT);
    assign flat_cause_o   = cause_q;

endmodule

/* msiptw/mrif_checker.sv */
`timescale 1ns/100ps

module mrif_checker (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               mrif_start_i,
    input  logic [msiptw_pkg::GPLEN-1:0]       iova_i,
    input  logic                               rsp_valid_i,
    input  logic                               rsp_err_i,
    input  logic [msiptw_pkg::WB_DW-1:0]       rsp_data_i,
    output logic                               rd_hi_o,
    output logic                               mrif_done_o,
    output logic                               ignore_o,
    output logic                               mrifc_update_o,
    output logic [msiptw_pkg::MRIF_ADDR_W-1:0] mrif_addr_o,
    output logic [msiptw_pkg::PPNW-1:0]        notice_ppn_o,
    output logic [msiptw_pkg::NID_W-1:0]       notice_nid_o,
    output logic                               mrif_error_o,
    output msiptw_pkg::msi_cause_e             mrif_cause_o
);

    typedef enum logic [1:0] {CHECK_LO, ISSUE_HI, CHECK_HI, FAULT} state_e;

    state_e                 state_q, state_n;
    msiptw_pkg::msi_cause_e cause_q, cause_n;
    logic                   ign_q, ign_n;
    logic                   upd_q, upd_n;
    logic                   lo_rsv;
    logic                   hi_rsv;

    // Reserved fields of both words
    assign lo_rsv = (|rsp_data_i[msiptw_pkg::MRIF_RSV_MSB:msiptw_pkg::W0_RSVL_LSB])
                 || (|rsp_data_i[msiptw_pkg::W0_RSVH_MSB:msiptw_pkg::W0_RSVH_LSB]);
    assign hi_rsv = (|rsp_data_i[msiptw_pkg::W1_RSVA_MSB:msiptw_pkg::W1_RSVA_LSB])
                 || (|rsp_data_i[msiptw_pkg::W1_RSVB_MSB:msiptw_pkg::W1_RSVB_LSB]);

    always_comb begin
        state_n = state_q;
        cause_n = cause_q;
        ign_n   = 1'b0;
        upd_n   = 1'b0;
        rd_hi_o = 1'b0;
        case (state_q)
            CHECK_LO: begin
                // Word 0 sits on rsp_data in the start cycle
                if (mrif_start_i) begin
                    if (lo_rsv) begin
                        cause_n = msiptw_pkg::CAUSE_PTE_MISCONF;
                        state_n = FAULT;
                    end else if (|iova_i[msiptw_pkg::PG_OFF_W-1:0]) begin
                        ign_n   = 1'b1;   // no byte access to MRIFs, drop silently
                    end else begin
                        state_n = ISSUE_HI;
                    end
                end
            end
            ISSUE_HI: begin
                rd_hi_o = 1'b1;
                state_n = CHECK_HI;
            end
            CHECK_HI: begin
                if (rsp_valid_i) begin
                    state_n = FAULT;
                    if (rsp_err_i) begin
                        cause_n = msiptw_pkg::CAUSE_DATA_CORRUPT;
                    end else if (hi_rsv) begin
                        cause_n = msiptw_pkg::CAUSE_PTE_MISCONF;
                    end else begin
                        upd_n   = 1'b1;
                        state_n = CHECK_LO;
                    end
                end
            end
            default: state_n = CHECK_LO;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CHECK_LO;
            cause_q <= msiptw_pkg::CAUSE_PTE_MISCONF;
            ign_q   <= 1'b0;
            upd_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            cause_q <= cause_n;
            ign_q   <= ign_n;
            upd_q   <= upd_n;
        end
    end

    // MRIF address from word 0, notice fields from word 1
    always_ff @(posedge clk_i) begin
        if (state_q == CHECK_LO && mrif_start_i) begin
            mrif_addr_o <= rsp_data_i[msiptw_pkg::MRIF_ADDR_MSB:msiptw_pkg::MRIF_ADDR_LSB];
        end
        if (upd_n) begin
            notice_ppn_o <= rsp_data_i[msiptw_pkg::NPPN_MSB:msiptw_pkg::NPPN_LSB];
            notice_nid_o <= {rsp_data_i[msiptw_pkg::NID_HI], rsp_data_i[msiptw_pkg::NID_LO_MSB:0]};
        end
    end

    // Done marks every terminating pulse of this FSM
    assign ignore_o       = ign_q;
    assign mrifc_update_o = upd_q;
    assign mrif_error_o   = (state_q == FAULT);
    assign mrif_cause_o   = cause_q;
    assign mrif_done_o    = ign_q || upd_q || (state_q == FAULT);

endmodule

/* rtl/msi_ptw_top.sv */
`timescale 1ns/100ps

module msi_ptw_top #(
    parameter bit MrifEn  = 1'b1,
    parameter int MaskLen = 16
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               start_i,
    input  logic [msiptw_pkg::GPLEN-1:0]       iova_i,
    input  logic                               is_rx_i,
    input  logic [msiptw_pkg::PPNW-1:0]        msiptp_ppn_i,
    input  logic [MaskLen-1:0]                 msi_mask_i,
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [msiptw_pkg::PLEN-1:0]        wb_adr_o,
    input  logic [msiptw_pkg::WB_DW-1:0]       wb_dat_i,
    input  logic                               wb_ack_i,
    input  logic                               wb_err_i,
    output logic                               busy_o,
    output logic                               iotlb_update_o,
    output logic [msiptw_pkg::PPNW-1:0]        iotlb_ppn_o,
    output logic                               mrifc_update_o,
    output logic [msiptw_pkg::MRIF_ADDR_W-1:0] mrif_addr_o,
    output logic [msiptw_pkg::PPNW-1:0]        notice_ppn_o,
    output logic [msiptw_pkg::NID_W-1:0]       notice_nid_o,
    output logic                               ignore_o,
    output logic                               error_o,
    output logic [msiptw_pkg::CAUSE_LEN-1:0]   cause_o
);

    logic                         rd_lo, rd_hi;
    logic [msiptw_pkg::PLEN-1:0]  base;
    logic                         rsp_valid, rsp_err;
    logic [msiptw_pkg::WB_DW-1:0] rsp_data;
    logic                         mrif_start, mrif_done;
    logic                         flat_error, mrif_error;
    msiptw_pkg::msi_cause_e       flat_cause, mrif_cause;

    // Shared Wishbone read port for both PTE words
    pte_reader i_reader (
        .clk_i, .rst_ni, .rd_lo_i(rd_lo), .rd_hi_i(rd_hi), .base_i(base),
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_i, .wb_ack_i, .wb_err_i,
        .rsp_valid_o(rsp_valid), .rsp_err_o(rsp_err), .rsp_data_o(rsp_data)
    );

    flat_walker #(.MrifEn(MrifEn), .MaskLen(MaskLen)) i_flat (
        .clk_i, .rst_ni, .start_i, .iova_i, .is_rx_i, .msiptp_ppn_i, .msi_mask_i,
        .rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err), .rsp_data_i(rsp_data),
        .mrif_done_i(mrif_done), .busy_o, .rd_lo_o(rd_lo), .base_o(base),
        .mrif_start_o(mrif_start), .iotlb_update_o, .iotlb_ppn_o,
        .flat_error_o(flat_error), .flat_cause_o(flat_cause)
    );

    mrif_checker i_mrif (
        .clk_i, .rst_ni, .mrif_start_i(mrif_start), .iova_i,
        .rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err), .rsp_data_i(rsp_data),
        .rd_hi_o(rd_hi), .mrif_done_o(mrif_done), .ignore_o, .mrifc_update_o,
        .mrif_addr_o, .notice_ppn_o, .notice_nid_o,
        .mrif_error_o(mrif_error), .mrif_cause_o(mrif_cause)
    );

    // Only one FSM can be in its fault state at a time
    assign error_o = flat_error || mrif_error;
    assign cause_o = flat_error ? flat_cause : (mrif_error ? mrif_cause : '0);

endmodule

/* test/msi_ptw_assertions.sv */
`timescale 1ns/100ps

module msi_ptw_assertions (
    input logic                        clk_i,
    input logic                        rst_ni,
    input logic                        start_i,
    input logic                        busy_i,
    input logic                        wb_cyc_i,
    input logic                        wb_stb_i,
    input logic                        wb_we_i,
    input logic [msiptw_pkg::PLEN-1:0] wb_adr_i,
    input logic                        wb_ack_i,
    input logic                        wb_err_i,
    input logic                        iotlb_update_i,
    input logic                        mrifc_update_i,
    input logic                        ignore_i,
    input logic                        error_i
);

    int fail_cnt = 0;

    // Strobe only inside an open cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni) wb_stb_i |-> wb_cyc_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wb_stb_o high without wb_cyc_o");
        end

    // Unanswered strobe keeps cyc, stb and address for the next cycle
    stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_stb_i && !wb_ack_i && !wb_err_i) |=> (wb_stb_i && wb_cyc_i && $stable(wb_adr_i)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wb_stb_o or wb_adr_o changed before ack or err");
        end

    // Read-only master
    we_low: assert property (@(posedge clk_i) disable iff (!rst_ni) !wb_we_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wb_we_o asserted");
        end

    // A walk ends with one pulse
    one_end_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({iotlb_update_i, mrifc_update_i, ignore_i, error_i}))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("more than one terminating pulse in a cycle");
        end

    // Accepted start makes the walker busy
    busy_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (start_i && !busy_i) |=> busy_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy_o did not rise after an accepted start");
        end

endmodule

bind msi_ptw_top msi_ptw_assertions asrt0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .busy_i         (busy_o),
    .wb_cyc_i       (wb_cyc_o),
    .wb_stb_i       (wb_stb_o),
    .wb_we_i        (wb_we_o),
    .wb_adr_i       (wb_adr_o),
    .wb_ack_i       (wb_ack_i),
    .wb_err_i       (wb_err_i),
    .iotlb_update_i (iotlb_update_o),
    .mrifc_update_i (mrifc_update_o),
    .ignore_i       (ignore_o),
    .error_i        (error_o)
);

/* test/tb_msi_ptw.sv */
`timescale 1ns/100ps

module tb_msi_ptw;

    localparam int NUM_WALKS    = 200;
    localparam int WALK_TIMEOUT = 100;

    logic                               clk_i = 1'b0;
    logic                               rst_ni;
    logic                               start_i;
    logic [msiptw_pkg::GPLEN-1:0]       iova_i;
    logic                               is_rx_i;
    logic [msiptw_pkg::PPNW-1:0]        msiptp_ppn_i;
    logic [15:0]                        msi_mask_i;
    logic                               wb_cyc_o;
    logic                               wb_stb_o;
    logic                               wb_we_o;
    logic [msiptw_pkg::PLEN-1:0]        wb_adr_o;
    logic [63:0]                        wb_dat_i;
    logic                               wb_ack_i;
    logic                               wb_err_i;
    logic                               busy_o;
    logic                               iotlb_update_o;
    logic [msiptw_pkg::PPNW-1:0]        iotlb_ppn_o;
    logic                               mrifc_update_o;
    logic [msiptw_pkg::MRIF_ADDR_W-1:0] mrif_addr_o;
    logic [msiptw_pkg::PPNW-1:0]        notice_ppn_o;
    logic [msiptw_pkg::NID_W-1:0]       notice_nid_o;
    logic                               ignore_o;
    logic                               error_o;
    logic [msiptw_pkg::CAUSE_LEN-1:0]   cause_o;

    // Stimulus of the current walk
    logic [msiptw_pkg::GPLEN-1:0] c_iova;
    logic [msiptw_pkg::PPNW-1:0]  c_ppn;
    logic [15:0]                  c_mask;
    logic                         c_rx;
    logic [63:0]                  w0;
    logic [63:0]                  w1;
    logic                         err_lo;
    logic                         err_hi;

    // Model predictions, pulse bits are {error, ignore, mrifc, iotlb}
    logic [msiptw_pkg::PLEN-1:0]  exp_addr;
    logic [3:0]                   exp_pulse;
    logic [11:0]                  exp_cause;
    logic [43:0]                  exp_ppn;
    logic [46:0]                  exp_maddr;
    logic [43:0]                  exp_nppn;
    logic [10:0]                  exp_nid;
    int                           exp_reads;

    // Memory model state
    logic [15:0]                  lfsr = 16'd61615;
    int                           rd_count;
    logic [msiptw_pkg::PLEN-1:0]  rd_addr [2];
    bit                           in_cycle;
    logic [1:0]                   wait_left;

    int mismatches = 0;
    int timeouts   = 0;

    msi_ptw_top dut0 (.*);

    always #10 clk_i = ~clk_i;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Wishbone slave, 0 to 3 wait states
    // First read of a walk returns word 0, the second word 1
    always begin
        @(posedge clk_i);
        #2;
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        wb_dat_i = 64'hffff_ffff_ffff_ffff;
        if (wb_stb_o) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = 2'(rand_bits(2));
                if (rd_count < 2) begin
                    rd_addr[rd_count] = wb_adr_o;
                end
                rd_count++;
            end
            if (wait_left == 2'd0) begin
                in_cycle = 1'b0;
                wb_dat_i = (rd_count == 1) ? w0 : w1;
                wb_err_i = (rd_count == 1) ? err_lo : err_hi;
                wb_ack_i = !wb_err_i;
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    // One random PTE shape per walk, then a single defect by kind
    task automatic build_case();
        int kind;
        int pos;
        kind   = int'(rand_bits(4)) % 12;
        c_iova = 41'(rand_bits(41));
        c_ppn  = 44'(rand_bits(44));
        c_mask = 16'(rand_bits(16));
        c_rx   = (kind == 5);
        err_lo = (kind == 9);
        err_hi = (kind == 10);
        w0     = rand_bits(64);
        w1     = rand_bits(64);
        w0[0]      = 1'b1;
        w0[63]     = 1'b0;
        w0[62:54]  = '0;
        w1[59:54]  = '0;
        w1[63:61]  = '0;
        if (kind < 6 || kind == 9) begin
            w0[2:1] = 2'd3;
            w0[9:3] = '0;
        end else begin
            w0[2:1]      = 2'd1;
            w0[6:3]      = '0;
            c_iova[11:0] = '0;
        end
        case (kind)
            1: begin
                pos     = rand_bits(1) ? 3 + int'(rand_bits(3)) % 7 : 54 + int'(rand_bits(4)) % 9;
                w0[pos] = 1'b1;
            end
            2: w0[0] = 1'b0;
            3: w0[63] = 1'b1;
            4: w0[2:1] = rand_bits(1) ? 2'd2 : 2'd0;
            6: c_iova[int'(rand_bits(4)) % 12] = 1'b1;
            8: begin
                pos     = rand_bits(1) ? 54 + int'(rand_bits(3)) % 6 : 61 + int'(rand_bits(2)) % 3;
                w1[pos] = 1'b1;
            end
            11: begin
                pos     = rand_bits(1) ? 3 + int'(rand_bits(2)) : 54 + int'(rand_bits(4)) % 9;
                w0[pos] = 1'b1;
            end
            default: ;
        endcase
    endtask

    // Reference model: PTE address and outcome by the check order
    task automatic predict();
        logic [15:0] file_num;
        file_num = '0;
        // Walk mask from the top so the lowest selected bit ends at bit 0
        for (int i = 15; i >= 0; i--) begin
            if (c_mask[i]) begin
                file_num = {file_num[14:0], c_iova[12 + i]};
            end
        end
        exp_addr  = {c_ppn, 12'h000} | (56'(file_num) << 4);
        exp_pulse = 4'b1000;
        exp_cause = msiptw_pkg::CAUSE_PTE_MISCONF;
        exp_reads = 1;
        if (c_rx) begin
            exp_cause = msiptw_pkg::CAUSE_INSTR_FAULT;
            exp_reads = 0;
        end else if (err_lo) begin
            exp_cause = msiptw_pkg::CAUSE_DATA_CORRUPT;
        end else if (!w0[0] || w0[63]) begin
            exp_cause = msiptw_pkg::CAUSE_PTE_INVALID;
        end else if (w0[2:1] == 2'd3) begin
            if (!(|w0[9:3]) && !(|w0[62:54])) begin
                exp_pulse = 4'b0001;
                exp_ppn   = w0[53:10];
            end
        end else if (w0[2:1] == 2'd1 && !(|w0[6:3]) && !(|w0[62:54])) begin
            if (|c_iova[11:0]) begin
                exp_pulse = 4'b0100;
            end else begin
                exp_reads = 2;
                if (err_hi) begin
                    exp_cause = msiptw_pkg::CAUSE_DATA_CORRUPT;
                end else if (!(|w1[59:54]) && !(|w1[63:61])) begin
                    exp_pulse = 4'b0010;
                    exp_maddr = w0[53:7];
                    exp_nppn  = w1[53:10];
                    exp_nid   = {w1[60], w1[9:0]};
                end
            end
        end
    endtask

    task automatic run_walk(output bit finished);
        logic [3:0] got_pulse;
        int         n;
        rd_count = 0;
        @(posedge clk_i);
        #2;
        start_i      = 1'b1;
        iova_i       = c_iova;
        is_rx_i      = c_rx;
        msiptp_ppn_i = c_ppn;
        msi_mask_i   = c_mask;
        @(posedge clk_i);
        #2;
        start_i   = 1'b0;
        got_pulse = '0;
        n         = 0;
        // Outputs sampled mid-cycle
        while (got_pulse == 4'b0000 && n < WALK_TIMEOUT) begin
            @(negedge clk_i);
            n++;
            got_pulse = {error_o, ignore_o, mrifc_update_o, iotlb_update_o};
        end
        finished = (got_pulse != 4'b0000);
        if (!finished) begin
            timeouts++;
            $display("Timeout: walk gave no update, ignore or error within %0d cycles",
                     WALK_TIMEOUT);
        end else begin
            expect_equal("terminating pulses", got_pulse, exp_pulse);
            if (exp_pulse[0]) begin
                expect_equal("iotlb_ppn_o", iotlb_ppn_o, exp_ppn);
            end
            if (exp_pulse[1]) begin
                expect_equal("mrif_addr_o", mrif_addr_o, exp_maddr);
                expect_equal("notice_ppn_o", notice_ppn_o, exp_nppn);
                expect_equal("notice_nid_o", notice_nid_o, exp_nid);
            end
            if (exp_pulse[3]) begin
                expect_equal("cause_o", cause_o, exp_cause);
            end
            if (c_rx) begin
                expect_equal("cycles to instruction fault", n, 2);
            end
            expect_equal("number of reads", rd_count, exp_reads);
            if (rd_count > 0) begin
                expect_equal("word 0 address", rd_addr[0], exp_addr);
            end
            if (rd_count > 1) begin
                expect_equal("word 1 address", rd_addr[1], exp_addr + 56'd8);
            end
            @(negedge clk_i);
            expect_equal("busy_o after walk", busy_o, 1'b0);
        end
    endtask

    initial begin
        bit finished;
        int assert_fails;
        rst_ni       = 1'b0;
        start_i      = 1'b0;
        iova_i       = '0;
        is_rx_i      = 1'b0;
        msiptp_ppn_i = '0;
        msi_mask_i   = '0;
        wb_dat_i     = '0;
        wb_ack_i     = 1'b0;
        wb_err_i     = 1'b0;
        in_cycle     = 1'b0;
        rd_count     = 0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        expect_equal("busy_o after reset", busy_o, 1'b0);
        expect_equal("wb_cyc_o/wb_stb_o after reset", {wb_cyc_o, wb_stb_o}, 2'b00);
        expect_equal("pulses after reset",
                     {iotlb_update_o, mrifc_update_o, ignore_o, error_o}, 4'b0000);
        finished = 1'b1;
        for (int k = 0; k < NUM_WALKS && finished; k++) begin
            build_case();
            predict();
            run_walk(finished);
        end
        assert_fails = dut0.asrt0.fail_cnt;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/msiptw_pkg.sv
msiptw/msi_addr_calc.sv
msiptw/pte_reader.sv
msiptw/flat_walker.sv
msiptw/mrif_checker.sv
rtl/msi_ptw_top.sv
test/msi_ptw_assertions.sv
test/tb_msi_ptw.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_msi_ptw
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the bench printed the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
